// File: hangmanTop.f
+incdir+.
gamePkg.sv
displayPkg.sv
guessPort.sv
guessFifo.sv
gameEngine.sv
hostDisplay.sv
hangmanTop.sv
hangmanProps.sv
hangmanTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= hangmanTb
FILELIST  ?= hangmanTop.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean build

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove build output and the log"
	@echo "  help   list these targets"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then exit 1; fi
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hangmanTb.sv
// ------------------------------------------------------------
// Directed tests over AXI4-Lite. Expected rows come from a model.
// bready and rready stay high except in the slow host test.
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "hangman_settings.svh"

module hangmanTb;
    import gamePkg::*;
    import displayPkg::*;

    localparam logic [1:0] OKAY    = 2'b00;
    localparam logic [1:0] SLVERR  = 2'b10;
    localparam int         TIMEOUT = 4000;  // all tests need well under 1000 cycles.

    logic        clk;
    logic        nRst;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    rowT         topRow;
    rowT         bottomRow;

    int errorCount = 0;
    int cycleCount = 0;

    // model of the game as the host should see it.
    logic [7:0] mWord [`WORD_LEN];
    logic [7:0] mText [`WORD_LEN];
    logic [7:0] mMiss [`MAX_MISTAKES];
    logic [4:0] mRevealed;
    logic [2:0] mMistakes;
    outcomeT    mOutcome;
    logic [1:0] lastResp;
    logic [7:0] burstLetters [7];
    int         okCount;
    int         errCount;

    hangmanTop DUT (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == TIMEOUT) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("TB FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // AXI4-Lite tasks
    task automatic axiWrite(input logic [31:0] addr, input logic [31:0] data,
                            input logic [1:0] expResp, input bit checkResp,
                            output logic [1:0] resp);
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do @(negedge clk); while (!awready);
        assert (wready) else begin
            $display("wready was not raised together with awready for %h", addr);
            errorCount++;
        end
        @(posedge clk);                     // the write is taken on this edge.
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(negedge clk);
        resp = bresp;
        assert (bvalid) else begin
            $display("write to %h got no response one cycle after acceptance", addr);
            errorCount++;
        end
        if (checkResp) begin
            assert (bresp == expResp) else begin
                $display("FAIL bresp: got %h, expected %h", bresp, expResp);
                errorCount++;
            end
        end
    endtask

    task automatic axiRead(input logic [31:0] addr, input logic [1:0] expResp,
                           output logic [31:0] data);
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        do @(negedge clk); while (!arready);
        @(posedge clk);
        arvalid <= 1'b0;
        @(negedge clk);
        data = rdata;
        assert (rvalid) else begin
            $display("read of %h got no data one cycle after acceptance", addr);
            errorCount++;
        end
        assert (rresp == expResp) else begin
            $display("FAIL rresp: got %h, expected %h", rresp, expResp);
            errorCount++;
        end
    endtask

    // ------------------------------------------------------------
    // reference model
    task automatic modelNewGame(input logic [39:0] w);
        for (int i = 0; i < `WORD_LEN; i++) begin
            mWord[i] = w[39-8*i -: 8];
            mText[i] = CH_UNDER;
        end
        for (int i = 0; i < `MAX_MISTAKES; i++) mMiss[i] = CH_UNDER;
        mRevealed = '0;
        mMistakes = '0;
        mOutcome  = PLAYING;
    endtask

    task automatic modelGuess(input logic [7:0] letter);
        bit inWord;
        bit newHit;
        inWord = 0;
        newHit = 0;
        if (mOutcome != PLAYING) return;    // late guesses are dropped.
        for (int i = 0; i < `WORD_LEN; i++) begin
            if (mWord[i] == letter) begin
                inWord = 1;
                if (!mRevealed[i]) begin
                    mRevealed[i] = 1'b1;
                    mText[i]     = letter;
                    newHit       = 1;
                end
            end
        end
        if (newHit) begin
            if (mRevealed == 5'h1F) mOutcome = WON;
        end else if (!inWord) begin
            for (int i = `MAX_MISTAKES-1; i > 0; i--) mMiss[i] = mMiss[i-1];
            mMiss[0]  = letter;
            mMistakes = mMistakes + 3'd1;
            if (mMistakes == 3'd6) mOutcome = LOST;
        end
    endtask

    function automatic rowT putChar(input rowT row, input int col, input logic [7:0] ch);
        rowT r;
        r = row;
        r[127-8*col -: 8] = ch;
        return r;
    endfunction

    function automatic logic [7:0] pickMiss();
        logic [7:0] c;
        bit         clash;
        do begin
            c     = 8'h41 + 8'($urandom % 26);
            clash = 0;
            for (int i = 0; i < `WORD_LEN; i++) if (mWord[i] == c) clash = 1;
        end while (clash);
        return c;
    endfunction

    task automatic checkRows();
        rowT expTop;
        rowT expBottom;
        expTop    = {16{8'h20}};
        expBottom = {16{8'h20}};
        if (mOutcome == PLAYING) begin
            for (int i = 0; i < 5; i++) expTop = putChar(expTop, 5 + i, mText[i]);
            for (int i = 0; i < 6; i++) expBottom = putChar(expBottom, 5 + i, mMiss[i]);
        end else begin
            if (mOutcome == WON) begin
                expTop = putChar(expTop, 6, "W");
                expTop = putChar(expTop, 7, "i");
                expTop = putChar(expTop, 8, "n");
            end else begin
                expTop = putChar(expTop, 6, "L");
                expTop = putChar(expTop, 7, "o");
                expTop = putChar(expTop, 8, "s");
                expTop = putChar(expTop, 9, "e");
            end
            for (int i = 0; i < 5; i++) expBottom = putChar(expBottom, 5 + i, mWord[i]);
        end
        @(negedge clk);
        assert (topRow == expTop) else begin
            $display("FAIL topRow: got %h, expected %h", topRow, expTop);
            errorCount++;
        end
        assert (bottomRow == expBottom) else begin
            $display("FAIL bottomRow: got %h, expected %h", bottomRow, expBottom);
            errorCount++;
        end
    endtask

    task automatic checkStatus();
        logic [31:0] d;
        logic [31:0] exp;
        exp = {21'b0, mOutcome, mMistakes, 3'($countones(mRevealed)), 3'b0};
        axiRead(`ADDR_STATUS, OKAY, d);
        assert (d == exp) else begin
            $display("FAIL rdata: got %h, expected %h", d, exp);
            errorCount++;
        end
    endtask

    // a guess keeps the engine busy for 7 cycles after its pop.
    task automatic waitIdle();
        logic [31:0] d;
        do axiRead(`ADDR_STATUS, OKAY, d); while (d[2:0] != 3'd0);
        repeat (8) @(posedge clk);
    endtask

    task automatic newGame(input logic [39:0] w);
        axiWrite(`ADDR_WORDLO, w[39:8], OKAY, 1, lastResp);
        axiWrite(`ADDR_WORDHI, {24'b0, w[7:0]}, OKAY, 1, lastResp);
        modelNewGame(w);
    endtask

    task automatic guess(input logic [7:0] letter);
        axiWrite(`ADDR_GUESS, {24'b0, letter}, OKAY, 1, lastResp);
        modelGuess(letter);
    endtask

    // ------------------------------------------------------------
    // directed tests
    task automatic testReset();
        logic [31:0] d;
        for (int i = 0; i < `WORD_LEN; i++) begin
            mWord[i] = 8'h20;
            mText[i] = CH_SPACE;
        end
        for (int i = 0; i < `MAX_MISTAKES; i++) mMiss[i] = CH_SPACE;
        mRevealed = '0;
        mMistakes = '0;
        mOutcome  = PLAYING;
        checkRows();    // model starts as playing, so spaces come from the text.
        checkStatus();
        axiRead(32'h10, SLVERR, d);
    endtask

    // a slow host leaves both responses waiting.
    task automatic testSlowHost();
        logic [31:0] d;
        @(posedge clk);
        bready <= 1'b0;
        rready <= 1'b0;
        axiWrite(`ADDR_WORDLO, 32'h0, OKAY, 1, lastResp);
        axiRead(`ADDR_STATUS, OKAY, d);
        assert (d == 32'h0) else begin
            $display("FAIL rdata: got %h, expected %h", d, 32'h0);
            errorCount++;
        end
        repeat (3) @(negedge clk);
        assert (bvalid && rvalid) else begin
            $display("a response was dropped before the host took it");
            errorCount++;
        end
        @(posedge clk);
        bready <= 1'b1;
        rready <= 1'b1;
    endtask

    task automatic testHits();
        newGame("APPLE");
        waitIdle();
        checkRows();
        guess("P");
        guess("E");
        waitIdle();
        checkRows();
        checkStatus();
    endtask

    task automatic testMisses();
        for (int i = 0; i < 3; i++) guess(pickMiss());
        waitIdle();
        checkRows();
        checkStatus();
    endtask

    task automatic testWin();
        guess("A");
        guess("L");
        waitIdle();
        checkRows();
        checkStatus();
        guess("Q");     // game is over, rows stay.
        waitIdle();
        checkRows();
        checkStatus();
    endtask

    task automatic testLose();
        newGame("GHOST");
        for (int i = 0; i < 6; i++) guess(pickMiss());
        waitIdle();
        checkRows();
        checkStatus();
    endtask

    task automatic testOverflow();
        logic [31:0] d;
        newGame("TRAIN");
        waitIdle();
        for (int i = 0; i < 7; i++) burstLetters[i] = pickMiss();
        okCount  = 0;
        errCount = 0;
        // a leading guess keeps the engine busy while six more queue up.
        for (int i = 0; i < 7; i++) begin
            axiWrite(`ADDR_GUESS, {24'b0, burstLetters[i]}, OKAY, 0, lastResp);
            if (lastResp == OKAY) begin
                okCount++;
                modelGuess(burstLetters[i]);
            end else begin
                errCount++;
            end
        end
        waitIdle();
        assert (errCount > 0) else begin
            $display("no guess write was refused although the FIFO overflowed");
            errorCount++;
        end
        axiRead(`ADDR_STATUS, OKAY, d);
        assert (int'(d[8:6]) == okCount) else begin
            $display("FAIL mistakes: got %h, expected %h", d[8:6], okCount);
            errorCount++;
        end
        checkRows();
        checkStatus();
    endtask

    initial begin
        void'($urandom(19055));
        nRst    = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b1;
        repeat (4) @(posedge clk);
        nRst <= 1'b1;
        testReset();
        testSlowHost();
        testHits();
        testMisses();
        testWin();
        testLose();
        testOverflow();
        $display("errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: hangmanProps.sv
// ------------------------------------------------------------
// Bound twice, tie off the ports that a target does not have.
// ------------------------------------------------------------
`timescale 1ns/1ps

module hangmanProps (
    input logic clk,
    input logic nRst,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready,
    input logic push,
    input logic full,
    input logic pop,
    input logic notEmpty
);

    // responses stay up until the host takes them.
    bHold: assert property (@(posedge clk) disable iff (!nRst)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    rHold: assert property (@(posedge clk) disable iff (!nRst)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    noPushFull: assert property (@(posedge clk) disable iff (!nRst) push |-> !full)
        else $error("push while the FIFO is full");

    noPopEmpty: assert property (@(posedge clk) disable iff (!nRst) pop |-> notEmpty)
        else $error("pop while the FIFO is empty");

endmodule

bind guessPort hangmanProps portProps (
    .clk, .nRst, .bvalid, .bready, .rvalid, .rready,
    .push, .full, .pop(1'b0), .notEmpty(1'b1)
);

bind guessFifo hangmanProps fifoProps (
    .clk, .nRst, .bvalid(1'b0), .bready(1'b1), .rvalid(1'b0), .rready(1'b1),
    .push, .full, .pop, .notEmpty
);

// File: hangmanTop.sv
// ------------------------------------------------------------
// AXI port feeds the guess FIFO, the engine drains it.
// ------------------------------------------------------------
`timescale 1ns/1ps

module hangmanTop (
    input  logic            clk,
    input  logic            nRst,
    input  logic [31:0]     awaddr,
    input  logic            awvalid,
    output logic            awready,
    input  logic [31:0]     wdata,
    input  logic            wvalid,
    output logic            wready,
    output logic [1:0]      bresp,
    output logic            bvalid,
    input  logic            bready,
    input  logic [31:0]     araddr,
    input  logic            arvalid,
    output logic            arready,
    output logic [31:0]     rdata,
    output logic [1:0]      rresp,
    output logic            rvalid,
    input  logic            rready,
    output displayPkg::rowT topRow,
    output displayPkg::rowT bottomRow
);
    import gamePkg::*;

    logic      push;
    itemT      pushItem;
    logic      full;
    logic [2:0] fifoLevel;
    logic      pop;
    itemT      popItem;
    logic      notEmpty;
    logic      evValid;
    gameEventT gameEvent;
    statusT    status;

    guessPort uPort (
        .clk, .nRst,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .push, .item(pushItem), .full, .status, .fifoLevel
    );

    guessFifo uFifo (
        .clk, .nRst, .push, .pushItem, .pop, .popItem, .notEmpty, .full,
        .level(fifoLevel)
    );

    gameEngine uEngine (
        .clk, .nRst, .notEmpty, .item(popItem), .pop, .evValid, .gameEvent, .status
    );

    hostDisplay uDisplay (
        .clk, .nRst, .evValid, .gameEvent, .topRow, .bottomRow
    );

endmodule

// File: hostDisplay.sv
// ------------------------------------------------------------
// Rows change on the edge after evValid. Misses beyond six letters
// fall off the right end of the list.
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "hangman_settings.svh"

module hostDisplay (
    input  logic               clk,
    input  logic               nRst,
    input  logic               evValid,
    input  gamePkg::gameEventT gameEvent,
    output displayPkg::rowT    topRow,
    output displayPkg::rowT    bottomRow
);
    import gamePkg::*;
    import displayPkg::*;

    localparam int ROW_BITS  = 8*`ROW_CHARS;
    localparam int WORD_BITS = 8*`WORD_LEN;
    localparam int LIST_BITS = 8*`MAX_MISTAKES;

    logic [WORD_BITS-1:0] wordText;
    logic [WORD_BITS-1:0] wordNext;
    logic [LIST_BITS-1:0] missList;
    logic [LIST_BITS-1:0] missNext;
    rowT                  topNext;
    rowT                  bottomNext;

    // ------------------------------------------------------------
    // text state after the event.
    always_comb begin
        wordNext = wordText;
        missNext = missList;
        case (gameEvent.kind)
            EV_NEWGAME: begin
                wordNext = {`WORD_LEN{CH_UNDER}};
                missNext = {`MAX_MISTAKES{CH_UNDER}};
            end
            EV_HIT: begin
                for (int i = 0; i < `WORD_LEN; i++) begin
                    if (gameEvent.hitMask[i]) begin
                        wordNext[WORD_BITS-1-8*i -: 8] = gameEvent.letter;
                    end
                end
            end
            EV_MISS: missNext = {gameEvent.letter, missList[LIST_BITS-1:8]};
            default: ;
        endcase
    end

    // rows are spaces except for the placed fields.
    always_comb begin
        topNext    = BLANK_ROW;
        bottomNext = BLANK_ROW;
        case (gameEvent.outcome)
            WON: begin
                topNext[ROW_BITS-1-8*TEXT_COL -: 24]           = TXT_WIN;
                bottomNext[ROW_BITS-1-8*WORD_COL -: WORD_BITS] = gameEvent.word;
            end
            LOST: begin
                topNext[ROW_BITS-1-8*TEXT_COL -: 32]           = TXT_LOSE;
                bottomNext[ROW_BITS-1-8*WORD_COL -: WORD_BITS] = gameEvent.word;
            end
            default: begin
                topNext[ROW_BITS-1-8*WORD_COL -: WORD_BITS]    = wordNext;
                bottomNext[ROW_BITS-1-8*LIST_COL -: LIST_BITS] = missNext;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            wordText  <= {`WORD_LEN{CH_SPACE}};
            missList  <= {`MAX_MISTAKES{CH_SPACE}};
            topRow    <= BLANK_ROW;
            bottomRow <= BLANK_ROW;
        end else if (evValid) begin
            wordText  <= wordNext;  // an ignored event rebuilds the same rows.
            missList  <= missNext;
            topRow    <= topNext;
            bottomRow <= bottomNext;
        end
    end

endmodule

// File: gameEngine.sv
// ------------------------------------------------------------
// Compares a guess one letter per cycle, so a guess takes 6 cycles
// plus the report cycle. Before the first game the word is spaces.
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "hangman_settings.svh"

module gameEngine (
    input  logic               clk,
    input  logic               nRst,
    input  logic               notEmpty,
    input  gamePkg::itemT      item,
    output logic               pop,
    output logic               evValid,
    output gamePkg::gameEventT gameEvent,
    output gamePkg::statusT    status
);
    import gamePkg::*;
    import displayPkg::*;

    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        REPORT
    } stateT;

    localparam logic [`WORD_LEN-1:0] ALL_REVEALED = '1;

    stateT                  state;
    logic [8*`WORD_LEN-1:0] word;
    logic [2:0]             pos;
    logic [`WORD_LEN-1:0]   hitMask;
    logic [`WORD_LEN-1:0]   revealed;
    logic [2:0]             mistakes;
    outcomeT                outcome;
    logic                   matchNow;
    logic                   lastPos;
    logic [`WORD_LEN-1:0]   hitNext;
    logic [`WORD_LEN-1:0]   newHits;
    logic [`WORD_LEN-1:0]   revealedNext;
    logic [2:0]             mistakesNext;
    outcomeT                outcomeNext;
    eventKindT              guessKind;

    assign pop     = (state == IDLE) && notEmpty;
    assign evValid = (state == REPORT);

    always_comb begin
        status.outcome   = outcome;
        status.mistakes  = mistakes;
        status.revealed  = 3'($countones(revealed));
        status.fifoLevel = 3'd0;    // filled in by the port.
    end

    // ------------------------------------------------------------
    // one position per cycle, letter 0 is the top byte of the word.
    assign matchNow = (word[8*(`WORD_LEN-1-pos) +: 8] == gameEvent.letter);
    assign lastPos  = (pos == 3'(`WORD_LEN-1));
    assign hitNext  = hitMask | ({{(`WORD_LEN-1){1'b0}}, matchNow} << pos);
    assign newHits  = hitNext & ~revealed;  // only positions not shown yet.

    // verdict of a guess, used on the last compare cycle.
    always_comb begin
        revealedNext = revealed | newHits;
        mistakesNext = mistakes;
        outcomeNext  = outcome;
        if (newHits != '0) begin
            guessKind = EV_HIT;
            if (revealedNext == ALL_REVEALED) begin
                outcomeNext = WON;
            end
        end else if (hitNext == '0) begin
            guessKind    = EV_MISS;
            mistakesNext = mistakes + 3'd1;
            if (mistakesNext == 3'(`MAX_MISTAKES)) begin
                outcomeNext = LOST;
            end
        end else begin
            guessKind = EV_IGNORED; // letter already revealed.
        end
    end

    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            state    <= IDLE;
            word     <= {`WORD_LEN{CH_SPACE}};
            revealed <= '0;
            mistakes <= '0;
            outcome  <= PLAYING;
            pos      <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (pop && item.op == OP_NEWGAME) begin
                        word     <= item.payload;
                        revealed <= '0;
                        mistakes <= '0;
                        outcome  <= PLAYING;
                        state    <= REPORT;
                    end else if (pop) begin
                        pos   <= '0;
                        state <= (outcome == PLAYING) ? COMPARE : REPORT;
                    end
                end
                COMPARE: begin
                    pos <= pos + 3'd1;
                    if (lastPos) begin
                        revealed <= revealedNext;
                        mistakes <= mistakesNext;
                        outcome  <= outcomeNext;
                        state    <= REPORT;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // event fields are captured at pop and finished on the last compare.
    always_ff @(posedge clk) begin
        if (pop) begin
            hitMask            <= '0;
            gameEvent.letter   <= item.payload[7:0];
            gameEvent.hitMask  <= '0;
            gameEvent.kind     <= (item.op == OP_NEWGAME) ? EV_NEWGAME : EV_IGNORED;
            gameEvent.word     <= (item.op == OP_NEWGAME) ? item.payload : word;
            gameEvent.outcome  <= (item.op == OP_NEWGAME) ? PLAYING : outcome;
            gameEvent.mistakes <= (item.op == OP_NEWGAME) ? 3'd0 : mistakes;
        end else if (state == COMPARE) begin
            hitMask <= hitNext;
            if (lastPos) begin
                gameEvent.kind     <= guessKind;
                gameEvent.hitMask  <= newHits;
                gameEvent.outcome  <= outcomeNext;
                gameEvent.mistakes <= mistakesNext;
            end
        end
    end

endmodule

// File: guessFifo.sv
// ------------------------------------------------------------
// Fall-through FIFO, so popItem is valid while notEmpty is high.
// Pointers wrap naturally, so the depth must be a power of two.
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "hangman_settings.svh"

module guessFifo (
    input  logic          clk,
    input  logic          nRst,
    input  logic          push,
    input  gamePkg::itemT pushItem,
    input  logic          pop,
    output gamePkg::itemT popItem,
    output logic          notEmpty,
    output logic          full,
    output logic [2:0]    level
);
    import gamePkg::*;

    localparam int PTR_W = $clog2(`FIFO_DEPTH);

    itemT             mem [`FIFO_DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic             doPush;
    logic             doPop;

    assign notEmpty = (level != 3'd0);
    assign full     = (level == 3'(`FIFO_DEPTH));
    assign popItem  = mem[rdPtr];

    assign doPush = push && !full;      // the port never pushes when full.
    assign doPop  = pop && notEmpty;

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushItem;
        end
    end

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            level <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            // push and pop together leave the level alone.
            if (doPush && !doPop) begin
                level <= level + 3'd1;
            end else if (doPop && !doPush) begin
                level <= level - 3'd1;
            end
        end
    end

endmodule

// File: guessPort.sv
// ------------------------------------------------------------
// AXI4-Lite slave, one transaction per channel, strobes ignored.
// A guess or new game into a full FIFO is refused with SLVERR.
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "hangman_settings.svh"

module guessPort (
    input  logic            clk,
    input  logic            nRst,
    input  logic [31:0]     awaddr,
    input  logic            awvalid,
    output logic            awready,
    input  logic [31:0]     wdata,
    input  logic            wvalid,
    output logic            wready,
    output logic [1:0]      bresp,
    output logic            bvalid,
    input  logic            bready,
    input  logic [31:0]     araddr,
    input  logic            arvalid,
    output logic            arready,
    output logic [31:0]     rdata,
    output logic [1:0]      rresp,
    output logic            rvalid,
    input  logic            rready,
    output logic            push,
    output gamePkg::itemT   item,
    input  logic            full,
    input  gamePkg::statusT status,
    input  logic [2:0]      fifoLevel
);
    import gamePkg::*;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic        wrAccept;
    logic        isWordLo;
    logic        isWordHi;
    logic        isGuess;
    logic [31:0] wordLo;
    statusT      statusWord;

    // ------------------------------------------------------------
    // write path
    assign wrAccept = awvalid && wvalid && !bvalid;  // AW and W taken together.
    assign awready  = wrAccept;
    assign wready   = wrAccept;

    assign isWordLo = (awaddr == `ADDR_WORDLO);
    assign isWordHi = (awaddr == `ADDR_WORDHI);
    assign isGuess  = (awaddr == `ADDR_GUESS);

    assign push = wrAccept && (isWordHi || isGuess) && !full;

    always_comb begin
        item.op      = isWordHi ? OP_NEWGAME : OP_GUESS;
        item.payload = isWordHi ? {wordLo, wdata[7:0]}
                                : {{(8*`WORD_LEN-8){1'b0}}, wdata[7:0]};
    end

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            bvalid <= 1'b0;
        end else if (wrAccept) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wrAccept) begin
            // status is read only, so a write there is refused too.
            bresp <= (isWordLo || push) ? RESP_OKAY : RESP_SLVERR;
            if (isWordLo) begin
                wordLo <= wdata;
            end
        end
    end

    // ------------------------------------------------------------
    // read path
    assign arready = arvalid && !rvalid;

    always_comb begin
        statusWord           = status;
        statusWord.fifoLevel = fifoLevel;   // level comes straight from the FIFO.
    end

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            rvalid <= 1'b0;
        end else if (arready) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (arready) begin
            if (araddr == `ADDR_STATUS) begin
                rdata <= {{(32-$bits(statusT)){1'b0}}, statusWord};
                rresp <= RESP_OKAY;
            end else begin
                rdata <= '0;
                rresp <= RESP_SLVERR;
            end
        end
    end

endmodule

// File: displayPkg.sv
// ------------------------------------------------------------
// Display types. Character 0 of a row sits in its top byte.
// ------------------------------------------------------------
`include "hangman_settings.svh"

package displayPkg;

    typedef logic [8*`ROW_CHARS-1:0] rowT;

    localparam logic [7:0]  CH_UNDER = 8'h5F;
    localparam logic [7:0]  CH_SPACE = 8'h20;
    localparam logic [23:0] TXT_WIN  = "Win";
    localparam logic [31:0] TXT_LOSE = "Lose";

    localparam rowT BLANK_ROW = {`ROW_CHARS{CH_SPACE}};

    // ------------------------------------------------------------
    // column where each field starts, counted from the left.
    localparam int WORD_COL = 5;    // revealed word and final word.
    localparam int LIST_COL = 5;    // six-slot miss list.
    localparam int TEXT_COL = 6;    // "Win" or "Lose".

endpackage

// File: gamePkg.sv
// ------------------------------------------------------------
// Game types. Letter 0 of a word sits in its top byte.
// ------------------------------------------------------------
`include "hangman_settings.svh"

package gamePkg;

    typedef enum logic {
        OP_NEWGAME = 1'b0,
        OP_GUESS   = 1'b1
    } opcodeT;

    typedef struct packed {
        opcodeT                 op;
        logic [8*`WORD_LEN-1:0] payload;    // word, or the letter in the low byte.
    } itemT;

    typedef enum logic [1:0] {
        PLAYING = 2'd0,
        WON     = 2'd1,
        LOST    = 2'd2
    } outcomeT;

    typedef enum logic [1:0] {
        EV_NEWGAME = 2'd0,
        EV_HIT     = 2'd1,
        EV_MISS    = 2'd2,
        EV_IGNORED = 2'd3
    } eventKindT;

    typedef struct packed {
        eventKindT              kind;
        logic [7:0]             letter;
        logic [`WORD_LEN-1:0]   hitMask;    // bit 0 is the leftmost letter.
        logic [8*`WORD_LEN-1:0] word;
        outcomeT                outcome;
        logic [2:0]             mistakes;
    } gameEventT;

    typedef struct packed {
        outcomeT    outcome;
        logic [2:0] mistakes;
        logic [2:0] revealed;
        logic [2:0] fifoLevel;
    } statusT;

endpackage

// File: hangman_settings.svh
// ------------------------------------------------------------
// Word length and row width are fixed by the two-row display.
// Register offsets are byte addresses on the AXI4-Lite port.
// ------------------------------------------------------------
`ifndef HANGMAN_SETTINGS_SVH
`define HANGMAN_SETTINGS_SVH

`define WORD_LEN     5      // letters in the secret word.
`define ROW_CHARS    16     // characters per display row.
`define MAX_MISTAKES 6      // misses that lose the game.
`define FIFO_DEPTH   4      // guess queue entries, a power of two.

// ------------------------------------------------------------
// register map
`define ADDR_WORDLO  32'h0  // letters 0 to 3, letter 0 in the top byte.
`define ADDR_WORDHI  32'h4  // letter 4 in the low byte, starts a game.
`define ADDR_GUESS   32'h8  // guessed letter in the low byte.
`define ADDR_STATUS  32'hC  // read only.

`endif
